// File: source/dprio_pkg.sv
// Shared definitions for the DPRIO configuration register block.
// Holds widths, the register address map, the scan chain layout and the
// packed structs that carry APB traffic, bank writes and test controls.
// Import it with a wildcard in the module header of each user.

package dprio_pkg;

  //**************************************************************************
  // Sizes
  //**************************************************************************
  localparam int DATA_WIDTH      = 16;
  localparam int ADDR_WIDTH      = 12;
  localparam int NUM_CTRL_REGS   = 8;
  localparam int NUM_SCAN_CHAINS = 2;
  localparam int REGS_PER_CHAIN  = NUM_CTRL_REGS / NUM_SCAN_CHAINS;
  localparam int BYTE_EN_WIDTH   = DATA_WIDTH / 8;
  localparam int IDX_WIDTH       = $clog2(NUM_CTRL_REGS);

  // Meaningful vector widths
  typedef logic [DATA_WIDTH-1:0]               cfg_data_t;
  typedef logic [ADDR_WIDTH-1:0]               cfg_addr_t;
  typedef logic [BYTE_EN_WIDTH-1:0]            byte_en_t;
  typedef logic [IDX_WIDTH-1:0]                reg_idx_t;
  typedef logic [NUM_SCAN_CHAINS-1:0]          scan_t;
  typedef logic [DATA_WIDTH*NUM_CTRL_REGS-1:0] cfg_bus_t;  // Register i in slice i

  //**************************************************************************
  // Address map
  //**************************************************************************
  localparam cfg_addr_t CTRL_BASE_ADDR = 12'h040;  // Control register 0
  localparam cfg_addr_t CTRL_END_ADDR  = CTRL_BASE_ADDR + cfg_addr_t'(NUM_CTRL_REGS);
  localparam cfg_addr_t BCAST_ADDR     = 12'h060;  // Write lands in every register
  localparam cfg_addr_t MODE_ADDR      = 12'h061;  // Bit 0 is the broadcast mode bit

  // True for any address inside the control register window
  function automatic logic is_ctrl_addr(cfg_addr_t addr);
    return (addr >= CTRL_BASE_ADDR) && (addr < CTRL_END_ADDR);
  endfunction

  //**************************************************************************
  // Packed structs
  //**************************************************************************
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    cfg_addr_t paddr;
    cfg_data_t pwdata;
    byte_en_t  pstrb;
  } apb_req_t;

  typedef struct packed {
    logic      pready;
    logic      pslverr;
    cfg_data_t prdata;
  } apb_rsp_t;

  // Write command from the APB slave to the register bank
  typedef struct packed {
    logic      write;      // One-cycle pulse
    logic      broadcast;  // Ignore the address match
    cfg_addr_t addr;
    cfg_data_t data;
    byte_en_t  byte_en;
  } reg_wr_t;

  typedef struct packed {
    logic csr_hold;   // Freeze the scan shadows
    logic csr_sel;    // 1 = shadow drives the output
    logic cram_gate;  // Force the output to zero
  } test_ctrl_t;

endpackage

// File: source/dprio_ctrl_reg.sv
// One 16-bit control register with its csr scan shadow.
// The dprio copy takes byte-enabled writes at its own address or on a
// broadcast. The shadow shifts one bit per cycle toward bit 0 unless held.
// The registered output is gated, or picks the shadow or the dprio copy.

module dprio_ctrl_reg
  import dprio_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  reg_idx_t   idx,        // Position in the bank
  input  reg_wr_t    wr,
  input  test_ctrl_t test_ctrl,
  input  logic       csr_in,     // Serial in, enters bit 15
  output logic       csr_out,    // Serial out, bit 0
  output cfg_data_t  dprio_q,
  output cfg_data_t  sig_out     // Towards the user logic
);

  cfg_addr_t target_addr;
  logic      wr_hit;
  cfg_data_t wr_merged;
  cfg_data_t csr_q;

  //**************************************************************************
  // Address match and byte merge
  //**************************************************************************
  assign target_addr = CTRL_BASE_ADDR + cfg_addr_t'(idx);
  assign wr_hit      = wr.write && (wr.broadcast || (wr.addr == target_addr));

  always_comb
  begin
    wr_merged = dprio_q;
    for (int b = 0; b < BYTE_EN_WIDTH; b++)
    begin
      if (wr.byte_en[b])
        wr_merged[b*8 +: 8] = wr.data[b*8 +: 8];
    end
  end

  // Bus-written copy
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      dprio_q <= '0;
    else if (wr_hit)
      dprio_q <= wr_merged;
  end

  //**************************************************************************
  // Scan shadow
  //**************************************************************************

  // Shifts right, new bit at the top
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      csr_q <= '0;
    else if (!test_ctrl.csr_hold)
      csr_q <= {csr_in, csr_q[DATA_WIDTH-1:1]};
  end

  assign csr_out = csr_q[0];  // Feeds the next register in the chain

  //**************************************************************************
  // Output select
  //**************************************************************************
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      sig_out <= '0;
    else if (test_ctrl.cram_gate)
      sig_out <= '0;             // Gated takes priority
    else if (test_ctrl.csr_sel)
      sig_out <= csr_q;
    else
      sig_out <= dprio_q;
  end

endmodule

// File: source/dprio_ctrl_reg_bank.sv
// Bank of control registers with scan chain stitching and readback.
// Registers are grouped into chains of REGS_PER_CHAIN in index order; each
// chain enters at its lowest register and leaves at its highest.
// Readback is combinational from the dprio copies.

module dprio_ctrl_reg_bank
  import dprio_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  reg_wr_t    wr,
  input  test_ctrl_t test_ctrl,
  input  scan_t      scan_in,
  output scan_t      scan_out,
  input  cfg_addr_t  rd_addr,
  output cfg_data_t  rd_data,
  output cfg_bus_t   cfg_out
);

  logic [NUM_CTRL_REGS-1:0] chain_in;
  logic [NUM_CTRL_REGS-1:0] chain_out;
  cfg_data_t                dprio_q [NUM_CTRL_REGS];
  cfg_addr_t                rd_offset;
  reg_idx_t                 rd_idx;

  //**************************************************************************
  // Register array
  //**************************************************************************
  for (genvar i = 0; i < NUM_CTRL_REGS; i++)
  begin : g_reg
    dprio_ctrl_reg ctrl_reg_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .idx       (reg_idx_t'(i)),
      .wr        (wr),
      .test_ctrl (test_ctrl),
      .csr_in    (chain_in[i]),
      .csr_out   (chain_out[i]),
      .dprio_q   (dprio_q[i]),
      .sig_out   (cfg_out[i*DATA_WIDTH +: DATA_WIDTH])
    );

    // First register of a chain takes the external scan input
    if ((i % REGS_PER_CHAIN) == 0)
    begin : g_head
      assign chain_in[i] = scan_in[i / REGS_PER_CHAIN];
    end
    else
    begin : g_link
      assign chain_in[i] = chain_out[i-1];
    end
  end

  // Chain tails
  for (genvar c = 0; c < NUM_SCAN_CHAINS; c++)
  begin : g_tail
    assign scan_out[c] = chain_out[(c+1)*REGS_PER_CHAIN - 1];
  end

  //**************************************************************************
  // Readback
  //**************************************************************************
  assign rd_offset = rd_addr - CTRL_BASE_ADDR;
  assign rd_idx    = reg_idx_t'(rd_offset);

  always_comb
  begin
    if (is_ctrl_addr(rd_addr))
      rd_data = dprio_q[rd_idx];
    else
      rd_data = '0;            // Outside the control window
  end

endmodule

// File: source/dprio_apb_slave.sv
// APB slave for the configuration register block.
// Every transfer takes one wait state. Decodes the control window, the
// broadcast address and the mode register, and flags anything else with
// pslverr. Issues one-cycle write pulses to the bank in the pready cycle.

module dprio_apb_slave
  import dprio_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  apb_req_t  apb_req,
  output apb_rsp_t  apb_rsp,
  output reg_wr_t   wr,
  output cfg_addr_t rd_addr,
  input  cfg_data_t rd_data
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,   // First access cycle, pready low
    ST_DONE    // Second access cycle, pready high
  } apb_state_e;

  apb_state_e state_q;
  apb_state_e state_d;
  logic       access;
  logic       addr_ctrl;
  logic       addr_bcast;
  logic       addr_mode;
  logic       addr_err;
  logic       mode_q;
  logic       pready_q;
  logic       pslverr_q;
  cfg_data_t  prdata_q;
  cfg_data_t  rd_value;

  //**************************************************************************
  // Decode
  //**************************************************************************
  assign access     = apb_req.psel && apb_req.penable;
  assign addr_ctrl  = is_ctrl_addr(apb_req.paddr);
  assign addr_bcast = (apb_req.paddr == BCAST_ADDR);
  assign addr_mode  = (apb_req.paddr == MODE_ADDR);
  assign addr_err   = !(addr_ctrl || addr_bcast || addr_mode);
  assign rd_addr    = apb_req.paddr;

  // Read source, zero for errors and the broadcast address
  always_comb
  begin
    if (addr_mode)
      rd_value = {{(DATA_WIDTH-1){1'b0}}, mode_q};
    else if (addr_ctrl)
      rd_value = rd_data;
    else
      rd_value = '0;
  end

  //**************************************************************************
  // Transfer FSM
  //**************************************************************************
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
        if (apb_req.psel && !apb_req.penable)
          state_d = ST_WAIT;
      ST_WAIT:
        state_d = access ? ST_DONE : ST_IDLE;
      default:
        state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q   <= ST_IDLE;
      pready_q  <= 1'b0;
      pslverr_q <= 1'b0;
      mode_q    <= 1'b0;
    end
    else
    begin
      state_q   <= state_d;
      pready_q  <= (state_q == ST_WAIT) && access;
      pslverr_q <= (state_q == ST_WAIT) && access && addr_err;
      // Mode bit commits in the pready cycle, low byte lane only
      if ((state_q == ST_DONE) && apb_req.pwrite && addr_mode && apb_req.pstrb[0])
        mode_q <= apb_req.pwdata[0];
    end
  end

  //**************************************************************************
  // Bank write command and read data
  //**************************************************************************
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      wr.write <= 1'b0;
    else
      wr.write <= (state_q == ST_WAIT) && access && apb_req.pwrite
                  && (addr_ctrl || addr_bcast);
    if (state_q == ST_WAIT)
    begin
      wr.broadcast <= addr_bcast || mode_q;
      wr.addr      <= apb_req.paddr;
      wr.data      <= apb_req.pwdata;
      wr.byte_en   <= apb_req.pstrb;
      prdata_q     <= apb_req.pwrite ? '0 : rd_value;
    end
  end

  assign apb_rsp = '{pready: pready_q, pslverr: pslverr_q, prdata: prdata_q};

endmodule

// File: source/dprio_cfg_top.sv
// Top level of the configuration register block.
// The APB slave feeds write commands into the register bank and reads
// back its values; test controls and scan pins go straight to the bank.

module dprio_cfg_top
  import dprio_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  apb_req_t   apb_req,
  output apb_rsp_t   apb_rsp,
  input  test_ctrl_t test_ctrl,
  input  scan_t      scan_in,
  output scan_t      scan_out,
  output cfg_bus_t   cfg_out
);

  reg_wr_t   wr;       // Bank write command
  cfg_addr_t rd_addr;
  cfg_data_t rd_data;

  //**************************************************************************
  // Bus side
  //**************************************************************************
  dprio_apb_slave apb_slave_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .wr      (wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  //**************************************************************************
  // Register storage
  //**************************************************************************
  dprio_ctrl_reg_bank reg_bank_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr        (wr),
    .test_ctrl (test_ctrl),
    .scan_in   (scan_in),
    .scan_out  (scan_out),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .cfg_out   (cfg_out)   // One slice per register
  );

endmodule

// File: test/dprio_cfg_tb.sv
// Testbench for the DPRIO configuration register block.
// Drives APB transfers, test controls and scan streams into the top level
// and checks prdata, pslverr, cfg_out and scan_out against a reference
// model of the register bank. Stops on its own or on the watchdog.

module dprio_cfg_tb
  import dprio_pkg::*;
();

  localparam int RESET_CYCLES    = 16;
  localparam int NUM_WRITES      = 32;
  localparam int NUM_ERRORS      = 12;
  localparam int NUM_GATED       = 4;
  localparam int PREADY_LIMIT    = 8;     // Access cycles before giving up
  localparam int ACCESS_CYCLES   = 2;     // One wait state, then pready
  localparam int CHAIN_LEN       = REGS_PER_CHAIN * DATA_WIDTH;
  localparam int STREAM_CYCLES   = 3 * CHAIN_LEN;
  localparam int HOLD_CYCLES     = 40;
  localparam int RELEASE_CYCLES  = 32;
  localparam int TRANSFER_COUNT  = NUM_WRITES + NUM_WRITES / 4 + NUM_ERRORS + NUM_GATED
                                   + 4 * NUM_CTRL_REGS + 9;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 6 * TRANSFER_COUNT + STREAM_CYCLES
                                   + HOLD_CYCLES + RELEASE_CYCLES + 40;

  logic       clk;
  logic       rst_n;
  apb_req_t   apb_req;
  apb_rsp_t   apb_rsp;
  test_ctrl_t test_ctrl;
  scan_t      scan_in;
  scan_t      scan_out;
  cfg_bus_t   cfg_out;

  // Reference model state
  cfg_data_t  model_dprio [NUM_CTRL_REGS];
  cfg_data_t  model_csr [NUM_CTRL_REGS];
  logic       model_mode;
  scan_t      scan_delay [$];   // Front is the bit due on scan_out

  // Expectations handed to the compare process
  logic        exp_pslverr;
  cfg_data_t   exp_prdata;
  logic        exp_is_read;
  cfg_bus_t    exp_cfg;
  scan_t       exp_scan;
  int          cfg_req_count = 0;
  int          cfg_done_count = 0;
  int          scan_req_count = 0;
  int          scan_done_count = 0;
  int          check_count = 0;
  int          mismatch_count = 0;
  int          fail_count = 0;
  logic [31:0] rng_state = 32'h75c6;

  dprio_cfg_top dprio_cfg_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .test_ctrl (test_ctrl),
    .scan_in   (scan_in),
    .scan_out  (scan_out),
    .cfg_out   (cfg_out)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //**************************************************************************
  // Random numbers and reference model
  //**************************************************************************
  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw_random(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value     = rng_state;
  endtask

  function automatic int ctrl_offset(cfg_addr_t addr);
    return int'(addr) - int'(CTRL_BASE_ADDR);   // Register index if in range
  endfunction

  function automatic logic addr_mapped(cfg_addr_t addr);
    int offset;
    offset = ctrl_offset(addr);
    return (offset >= 0 && offset < NUM_CTRL_REGS) || addr == BCAST_ADDR || addr == MODE_ADDR;
  endfunction

  function automatic cfg_data_t merge_bytes(cfg_data_t old_value, cfg_data_t new_value,
                                            byte_en_t strb);
    cfg_data_t merged;
    merged = old_value;
    for (int b = 0; b < DATA_WIDTH / 8; b++)
    begin
      if (strb[b])
        merged[b*8 +: 8] = new_value[b*8 +: 8];
    end
    return merged;
  endfunction

  // Expected {pslverr, prdata} of a read
  function automatic logic [DATA_WIDTH:0] ref_read(cfg_addr_t addr);
    int offset;
    offset = ctrl_offset(addr);
    if (offset >= 0 && offset < NUM_CTRL_REGS)
      return {1'b0, model_dprio[offset]};
    else if (addr == MODE_ADDR)
      return {1'b0, {(DATA_WIDTH-1){1'b0}}, model_mode};
    else if (addr == BCAST_ADDR)
      return '0;
    return {1'b1, {DATA_WIDTH{1'b0}}};
  endfunction

  // Expected cfg_out after an edge that samples tc
  function automatic cfg_bus_t ref_cfg(test_ctrl_t tc);
    cfg_bus_t bus;
    bus = '0;
    if (!tc.cram_gate)
    begin
      for (int i = 0; i < NUM_CTRL_REGS; i++)
        bus[i*DATA_WIDTH +: DATA_WIDTH] = tc.csr_sel ? model_csr[i] : model_dprio[i];
    end
    return bus;
  endfunction

  task automatic model_write(input cfg_addr_t addr, input cfg_data_t data, input byte_en_t strb);
    int offset;
    offset = ctrl_offset(addr);
    if (addr == MODE_ADDR)
    begin
      if (strb[0])
        model_mode = data[0];
    end
    else if (addr == BCAST_ADDR || (model_mode && offset >= 0 && offset < NUM_CTRL_REGS))
    begin
      for (int i = 0; i < NUM_CTRL_REGS; i++)
        model_dprio[i] = merge_bytes(model_dprio[i], data, strb);
    end
    else if (offset >= 0 && offset < NUM_CTRL_REGS)
      model_dprio[offset] = merge_bytes(model_dprio[offset], data, strb);
  endtask

  // One shift of every chain from the last register back
  task automatic model_shift(input scan_t bits);
    int   head;
    logic carry;
    for (int c = 0; c < NUM_SCAN_CHAINS; c++)
    begin
      head = c * REGS_PER_CHAIN;
      for (int i = head + REGS_PER_CHAIN - 1; i >= head; i--)
      begin
        if (i == head)
          carry = bits[c];
        else
          carry = model_csr[i-1][0];
        model_csr[i] = {carry, model_csr[i][DATA_WIDTH-1:1]};
      end
    end
  endtask

  //**************************************************************************
  // Stimulus tasks
  //**************************************************************************
  task automatic post_cfg_check();
    exp_cfg = ref_cfg(test_ctrl);   // Value the DUT sampled at this edge
    cfg_req_count++;
  endtask

  task automatic set_test_ctrl(input logic hold, input logic sel, input logic gate);
    @(posedge clk);
    test_ctrl <= '{csr_hold: hold, csr_sel: sel, cram_gate: gate};
  endtask

  task automatic apb_transfer(input logic write, input cfg_addr_t addr, input cfg_data_t data,
                              input byte_en_t strb);
    logic [DATA_WIDTH:0] expected;
    int                  waited;
    expected    = ref_read(addr);
    exp_pslverr = expected[DATA_WIDTH];
    exp_prdata  = expected[DATA_WIDTH-1:0];
    exp_is_read = !write;
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data,
                 pstrb: strb};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    waited = 0;
    do
    begin
      @(negedge clk);
      waited++;
    end while (!apb_rsp.pready && waited < PREADY_LIMIT);
    assert (apb_rsp.pready)
    else
    begin
      fail_count++;
      $display("pready did not rise within %0d cycles at address %h", PREADY_LIMIT, addr);
    end
    assert (!apb_rsp.pready || waited == ACCESS_CYCLES)
    else
    begin
      mismatch_count++;
      $display("MISMATCH at %0t: pready access cycles expected %0d got %0d", $time,
               ACCESS_CYCLES, waited);
    end
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
    if (write && !exp_pslverr)
      model_write(addr, data, strb);
    @(posedge clk);
    post_cfg_check();               // Write plus registered output select
  endtask

  task automatic apb_write(input cfg_addr_t addr, input cfg_data_t data, input byte_en_t strb);
    apb_transfer(1'b1, addr, data, strb);
  endtask

  task automatic apb_read(input cfg_addr_t addr);
    apb_transfer(1'b0, addr, '0, '0);
  endtask

  task automatic read_all_regs();
    for (int i = 0; i < NUM_CTRL_REGS; i++)
      apb_read(CTRL_BASE_ADDR + cfg_addr_t'(i));
  endtask

  // Random serial stream into every chain with csr_hold driven to hold
  task automatic stream_scan(input int cycles, input logic hold);
    logic [31:0] r;
    test_ctrl_t  tc_seen;
    scan_t       bits_seen;
    for (int n = 0; n < cycles; n++)
    begin
      @(posedge clk);
      tc_seen   = test_ctrl;
      bits_seen = scan_in;
      exp_cfg   = ref_cfg(tc_seen);  // Shadow before this shift
      if (!tc_seen.csr_hold)
      begin
        model_shift(bits_seen);
        scan_delay.delete(0);
        scan_delay.push_back(bits_seen);
      end
      exp_scan = scan_delay[0];
      cfg_req_count++;
      scan_req_count++;
      draw_random(r);
      scan_in <= scan_t'(r >> 7);
      test_ctrl.csr_hold <= hold;
    end
  endtask

  //**************************************************************************
  // Compare process
  //**************************************************************************
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (apb_rsp.pready)
      begin
        check_count++;
        assert (apb_rsp.pslverr == exp_pslverr)
        else
        begin
          mismatch_count++;
          $display("MISMATCH at %0t: pslverr expected %b got %b", $time, exp_pslverr,
                   apb_rsp.pslverr);
        end
        if (exp_is_read)
        begin
          check_count++;
          assert (apb_rsp.prdata == exp_prdata)
          else
          begin
            mismatch_count++;
            $display("MISMATCH at %0t: prdata expected %h got %h", $time, exp_prdata,
                     apb_rsp.prdata);
          end
        end
      end
      if (cfg_req_count != cfg_done_count)
      begin
        check_count++;
        assert (cfg_out == exp_cfg)
        else
        begin
          mismatch_count++;
          $display("MISMATCH at %0t: cfg_out expected %h got %h", $time, exp_cfg, cfg_out);
        end
        cfg_done_count = cfg_req_count;
      end
      if (scan_req_count != scan_done_count)
      begin
        check_count++;
        assert (scan_out == exp_scan)
        else
        begin
          mismatch_count++;
          $display("MISMATCH at %0t: scan_out expected %b got %b", $time, exp_scan, scan_out);
        end
        scan_done_count = scan_req_count;
      end
    end
  end

  //**************************************************************************
  // Test sequence
  //**************************************************************************
  initial
  begin : stimulus
    logic [31:0] r;
    cfg_addr_t   addr;
    apb_req   = '0;
    test_ctrl = '0;
    scan_in   = '0;
    rst_n     = 1'b0;
    model_mode = 1'b0;
    for (int i = 0; i < NUM_CTRL_REGS; i++)
    begin
      model_dprio[i] = '0;
      model_csr[i]   = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    post_cfg_check();                // All zero out of reset

    // Random single writes with readbacks
    for (int n = 0; n < NUM_WRITES; n++)
    begin
      draw_random(r);
      addr = CTRL_BASE_ADDR + cfg_addr_t'(reg_idx_t'(r));
      apb_write(addr, cfg_data_t'(r >> 16), byte_en_t'(r >> 8));
      if (n % 4 == 3)
        apb_read(addr);
    end
    read_all_regs();

    // Broadcast by address and then by mode bit
    draw_random(r);
    apb_write(BCAST_ADDR, cfg_data_t'(r >> 16), 2'b01);
    read_all_regs();
    apb_read(BCAST_ADDR);
    apb_write(MODE_ADDR, 16'h0001, 2'b01);
    apb_read(MODE_ADDR);
    draw_random(r);
    apb_write(CTRL_BASE_ADDR + 12'd3, cfg_data_t'(r >> 16), 2'b10);
    read_all_regs();
    apb_write(MODE_ADDR, 16'hfffe, 2'b11);
    apb_read(MODE_ADDR);
    draw_random(r);
    apb_write(CTRL_BASE_ADDR + 12'd5, cfg_data_t'(r >> 16), 2'b11);   // Single again

    // Unmapped addresses with the window edges first
    for (int n = 0; n < NUM_ERRORS; n++)
    begin
      if (n == 0)
        addr = CTRL_BASE_ADDR - 12'd1;
      else if (n == 1)
        addr = CTRL_BASE_ADDR + cfg_addr_t'(NUM_CTRL_REGS);
      else
      begin
        do
        begin
          draw_random(r);
          addr = cfg_addr_t'(r);
        end while (addr_mapped(addr));
      end
      draw_random(r);
      apb_transfer(n % 2 == 0, addr, cfg_data_t'(r), 2'b11);
    end
    read_all_regs();

    // Gated output
    set_test_ctrl(1'b0, 1'b0, 1'b1);
    for (int n = 0; n < NUM_GATED; n++)
    begin
      draw_random(r);
      apb_write(CTRL_BASE_ADDR + cfg_addr_t'(reg_idx_t'(r)), cfg_data_t'(r >> 16), 2'b11);
    end
    set_test_ctrl(1'b0, 1'b0, 1'b0);
    draw_random(r);
    apb_write(CTRL_BASE_ADDR, cfg_data_t'(r >> 16), 2'b11);

    // Scan chains with the shadow on the output
    for (int i = 0; i < CHAIN_LEN; i++)
      scan_delay.push_back('0);
    set_test_ctrl(1'b0, 1'b1, 1'b0);
    stream_scan(STREAM_CYCLES, 1'b0);
    stream_scan(HOLD_CYCLES, 1'b1);
    stream_scan(RELEASE_CYCLES, 1'b0);
    scan_in <= '0;
    repeat (2) @(posedge clk);

    $display("Checks: %0d, mismatches: %0d, other errors: %0d", check_count, mismatch_count,
             fail_count);
    if (mismatch_count == 0 && fail_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  // Watchdog
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the test sequence did not finish",
             WATCHDOG_CYCLES);
    $display("Checks: %0d, mismatches: %0d, other errors: %0d", check_count, mismatch_count,
             fail_count);
    $display("Errors found");
    $finish;
  end

endmodule

// File: dprio_cfg_top.f
source/dprio_pkg.sv
source/dprio_ctrl_reg.sv
source/dprio_ctrl_reg_bank.sv
source/dprio_apb_slave.sv
source/dprio_cfg_top.sv
test/dprio_cfg_tb.sv

// File: Makefile
# Verilator build and run of the DPRIO configuration block testbench
# make run builds the simulator if a source changed, runs it and fails
# unless the testbench reports a clean run

SIM  := obj_dir/Vdprio_cfg_tb
SRCS := $(wildcard source/*.sv) test/dprio_cfg_tb.sv

.PHONY: all run clean

all: $(SIM)

$(SIM): dprio_cfg_top.f $(SRCS)
	verilator --binary --timing --assert -f dprio_cfg_top.f \
		--top-module dprio_cfg_tb -o Vdprio_cfg_tb

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
